// ==== design/vid_pkg.sv ====
/*
 * Video subsystem shared definitions
 * Frame geometry, CPU address map, tile map and palette entry layouts,
 * and the raster and pixel records passed between the pipeline stages
 */
`default_nettype none

package vid_pkg;

    // Frame geometry, one pixel per clock
    localparam logic [8:0] H_TOTAL  = 9'd64;
    localparam logic [8:0] H_VIS    = 9'd48;
    localparam logic [8:0] V_TOTAL  = 9'd40;
    localparam logic [8:0] V_VIS    = 9'd32;
    localparam logic [8:0] HS_START = 9'd52;
    localparam logic [8:0] HS_END   = 9'd55;
    localparam logic [8:0] VS_START = 9'd34;
    localparam logic [8:0] VS_END   = 9'd35;

    // Raster coordinate to RGB, and CPU read strobe to data
    localparam int PIX_LAT = 5;
    localparam int RD_LAT  = 2;

    // CPU address map, 64-word regions
    localparam logic [8:0] MAP0_BASE = 9'h000;
    localparam logic [8:0] MAP1_BASE = 9'h040;
    localparam logic [8:0] PAL_BASE  = 9'h080;
    localparam logic [8:0] CTRL_BASE = 9'h0C0;

    // Control register offsets inside CTRL_BASE
    localparam logic [5:0] REG_HSCR0 = 6'd0;
    localparam logic [5:0] REG_VSCR0 = 6'd1;
    localparam logic [5:0] REG_HSCR1 = 6'd2;
    localparam logic [5:0] REG_VSCR1 = 6'd3;
    localparam logic [5:0] REG_PRIO  = 6'd4;

    typedef struct packed {
        logic       flip_x;
        logic [3:0] color;
        logic [2:0] unused;
        logic [7:0] code;
    } tile_entry_t;

    typedef struct packed {
        logic       unused;
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } pal_entry_t;

    // CPU data word, seen as a map entry or a palette entry
    typedef union packed {
        tile_entry_t tile;
        pal_entry_t  pal;
    } cpu_word_u;

    // Index 0 is transparent
    typedef struct packed {
        logic [3:0] color;
        logic [3:0] index;
    } layer_pxl_t;

    typedef struct packed {
        logic [8:0] hscr;
        logic [8:0] vscr;
    } scroll_t;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       lhbl;
        logic       lvbl;
    } raster_t;

endpackage

`default_nettype wire

// ==== design/vid_timing.sv ====
/*
 * Raster timing generator
 * Free-running pixel and line counters with blanking and sync decode
 */
`timescale 1ns/1ps
`default_nettype none

module vid_timing (
    input  wire logic             clk,
    input  wire logic             arst_n,
    output vid_pkg::raster_t      raster,
    output logic                  hs,
    output logic                  vs
);

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic       h_wrap;
    logic       v_wrap;

    assign h_wrap = (hcnt == vid_pkg::H_TOTAL - 9'd1);
    assign v_wrap = (vcnt == vid_pkg::V_TOTAL - 9'd1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            if (h_wrap) begin
                hcnt <= '0;
                // Line advances only at the end of each line
                if (v_wrap) begin
                    vcnt <= '0;
                end else begin
                    vcnt <= vcnt + 9'd1;
                end
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    // Blanking rides with the coordinates
    assign raster.hdump = hcnt;
    assign raster.vdump = vcnt;
    assign raster.lhbl  = (hcnt < vid_pkg::H_VIS);
    assign raster.lvbl  = (vcnt < vid_pkg::V_VIS);

    assign hs = (hcnt >= vid_pkg::HS_START) && (hcnt <= vid_pkg::HS_END);
    assign vs = (vcnt >= vid_pkg::VS_START) && (vcnt <= vid_pkg::VS_END);

endmodule

`default_nettype wire

// ==== design/vid_regs.sv ====
/*
 * CPU register decoder
 * Splits the address into map, palette and control regions, issues the
 * write strobes, holds scroll and priority, and returns read data
 */
`timescale 1ns/1ps
`default_nettype none

module vid_regs (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic [8:0]         cpu_addr,
    input  vid_pkg::cpu_word_u      cpu_din,
    input  wire logic               cpu_we,
    input  wire logic               cpu_rd,
    input  wire logic [15:0]        map0_rdata,
    input  wire logic [15:0]        map1_rdata,
    input  wire logic [15:0]        pal_rdata,
    output logic [5:0]              map_widx,
    output logic [5:0]              pal_widx,
    output logic                    map0_we,
    output logic                    map1_we,
    output logic                    pal_we,
    output vid_pkg::cpu_word_u      wdata,
    output vid_pkg::scroll_t        scroll0,
    output vid_pkg::scroll_t        scroll1,
    output logic                    prio,
    output logic [15:0]             cpu_dout
);

    logic [15:0] din_bits;
    logic        hit_map0;
    logic        hit_map1;
    logic        hit_pal;
    logic        hit_ctrl;
    logic [15:0] local_rdata;
    logic        rd_pend;
    logic [2:0]  rd_sel;
    logic [15:0] local_q;

    assign din_bits = cpu_din;

    // Region select from the top three address bits
    assign hit_map0 = (cpu_addr[8:6] == vid_pkg::MAP0_BASE[8:6]);
    assign hit_map1 = (cpu_addr[8:6] == vid_pkg::MAP1_BASE[8:6]);
    assign hit_pal  = (cpu_addr[8:6] == vid_pkg::PAL_BASE[8:6]);
    assign hit_ctrl = (cpu_addr[8:6] == vid_pkg::CTRL_BASE[8:6]);

    assign map0_we  = cpu_we & hit_map0;
    assign map1_we  = cpu_we & hit_map1;
    assign pal_we   = cpu_we & hit_pal;
    assign map_widx = cpu_addr[5:0];
    assign pal_widx = cpu_addr[5:0];
    assign wdata    = cpu_din;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scroll0 <= '0;
            scroll1 <= '0;
            prio    <= 1'b0;
        end else if (cpu_we && hit_ctrl) begin
            case (cpu_addr[5:0])
                vid_pkg::REG_HSCR0: scroll0.hscr <= din_bits[8:0];
                vid_pkg::REG_VSCR0: scroll0.vscr <= din_bits[8:0];
                vid_pkg::REG_HSCR1: scroll1.hscr <= din_bits[8:0];
                vid_pkg::REG_VSCR1: scroll1.vscr <= din_bits[8:0];
                vid_pkg::REG_PRIO:  prio         <= din_bits[0];
                default: ;
            endcase
        end
    end

    // Locally served words, unmapped reads as all ones
    always_comb begin
        local_rdata = 16'hffff;
        if (hit_ctrl) begin
            case (cpu_addr[5:0])
                vid_pkg::REG_HSCR0: local_rdata = {7'd0, scroll0.hscr};
                vid_pkg::REG_VSCR0: local_rdata = {7'd0, scroll0.vscr};
                vid_pkg::REG_HSCR1: local_rdata = {7'd0, scroll1.hscr};
                vid_pkg::REG_VSCR1: local_rdata = {7'd0, scroll1.vscr};
                vid_pkg::REG_PRIO:  local_rdata = {15'd0, prio};
                default:            local_rdata = 16'hffff;
            endcase
        end
    end

    // First read clock, RAMs register their word in parallel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_pend <= 1'b0;
            rd_sel  <= '0;
            local_q <= '0;
        end else begin
            rd_pend <= cpu_rd;
            if (cpu_rd) begin
                rd_sel  <= {hit_pal, hit_map1, hit_map0};
                local_q <= local_rdata;
            end
        end
    end

    // Second read clock, output holds until the next read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cpu_dout <= '0;
        end else if (rd_pend) begin
            case (rd_sel)
                3'b001:  cpu_dout <= map0_rdata;
                3'b010:  cpu_dout <= map1_rdata;
                3'b100:  cpu_dout <= pal_rdata;
                default: cpu_dout <= local_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/tile_layer.sv ====
/*
 * Scrolling tile layer
 * 64-entry tile map with a CPU port and a raster port, followed by a
 * map read, pattern ROM fetch and pixel select pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module tile_layer #(
    parameter int MAP_COLS = 8,
    parameter int MAP_ROWS = 8
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  vid_pkg::raster_t        raster,
    input  vid_pkg::scroll_t        scroll,
    input  wire logic               map_we,
    input  wire logic [5:0]         map_widx,
    input  vid_pkg::cpu_word_u      wdata,
    input  wire logic [5:0]         map_ridx,
    output logic [15:0]             map_rdata,
    output logic [10:0]             rom_addr,
    input  wire logic [31:0]        rom_data,
    output vid_pkg::layer_pxl_t     pxl
);

    localparam int COL_W = $clog2(MAP_COLS);
    localparam int ROW_W = $clog2(MAP_ROWS);

    vid_pkg::tile_entry_t map_mem [0:63];

    logic [8:0]           scr_x;
    logic [8:0]           scr_y;
    logic [COL_W-1:0]     tile_col;
    logic [ROW_W-1:0]     tile_row;
    logic [5:0]           map_idx;

    // Stage 1 map entry and pixel offsets
    vid_pkg::tile_entry_t s1_entry;
    logic [2:0]           s1_row;
    logic [2:0]           s1_col;

    // Stage 2 attributes riding along the ROM fetch
    logic [3:0]           s2_color;
    logic [2:0]           s2_col;

    // Scrolled coordinate, wraps at 512 and again at the map size
    assign scr_x    = raster.hdump + scroll.hscr;
    assign scr_y    = raster.vdump + scroll.vscr;
    assign tile_col = scr_x[3 +: COL_W];
    assign tile_row = scr_y[3 +: ROW_W];
    assign map_idx  = {tile_row, tile_col};

    always_ff @(posedge clk) begin
        if (map_we) begin
            map_mem[map_widx] <= wdata.tile;
        end
        map_rdata <= map_mem[map_ridx];
    end

    always_ff @(posedge clk) begin
        s1_entry <= map_mem[map_idx];
        s1_row   <= scr_y[2:0];
        s1_col   <= scr_x[2:0];
    end

    // ROM samples the address on the same edge that closes stage 2
    assign rom_addr = {s1_entry.code, s1_row};

    always_ff @(posedge clk) begin
        s2_color <= s1_entry.color;
        s2_col   <= s1_entry.flip_x ? ~s1_col : s1_col;
    end

    // Pixel 0 sits in the low nibble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl <= '0;
        end else begin
            pxl.color <= s2_color;
            pxl.index <= rom_data[{s2_col, 2'b00} +: 4];
        end
    end

endmodule

`default_nettype wire

// ==== design/pal_mixer.sv ====
/*
 * Palette mixer
 * Picks the visible layer by priority and transparency, looks the pixel
 * up in the palette RAM and drives RGB with delayed blanking
 */
`timescale 1ns/1ps
`default_nettype none

module pal_mixer (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  vid_pkg::raster_t        raster,
    input  wire logic               prio,
    input  vid_pkg::layer_pxl_t     pxl0,
    input  vid_pkg::layer_pxl_t     pxl1,
    input  wire logic               pal_we,
    input  wire logic [5:0]         pal_widx,
    input  vid_pkg::cpu_word_u      wdata,
    input  wire logic [5:0]         pal_ridx,
    output logic [15:0]             pal_rdata,
    output logic [7:0]              red,
    output logic [7:0]              green,
    output logic [7:0]              blue,
    output logic                    lhbl_dly,
    output logic                    lvbl_dly
);

    // Blanking pipe up to the palette read stage
    localparam int BL_DEPTH = vid_pkg::PIX_LAT - 1;

    vid_pkg::pal_entry_t pal_mem [0:63];

    vid_pkg::layer_pxl_t top_pxl;
    vid_pkg::layer_pxl_t bot_pxl;
    vid_pkg::layer_pxl_t sel_pxl;
    logic                sel_layer;
    logic [5:0]          pal_addr;
    vid_pkg::pal_entry_t pal_q;
    logic [BL_DEPTH-1:0] lhbl_sr;
    logic [BL_DEPTH-1:0] lvbl_sr;
    logic                vis;

    always_comb begin
        top_pxl = prio ? pxl1 : pxl0;
        bot_pxl = prio ? pxl0 : pxl1;
        if (top_pxl.index != 4'd0) begin
            sel_pxl   = top_pxl;
            sel_layer = prio;
        end else begin
            // Transparent top, lower layer shows through
            sel_pxl   = bot_pxl;
            sel_layer = ~prio;
        end
    end

    assign pal_addr = {sel_layer, sel_pxl.color[0], sel_pxl.index};

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[pal_widx] <= wdata.pal;
        end
        pal_rdata <= pal_mem[pal_ridx];
        pal_q     <= pal_mem[pal_addr];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lhbl_sr <= '0;
            lvbl_sr <= '0;
        end else begin
            lhbl_sr <= {lhbl_sr[BL_DEPTH-2:0], raster.lhbl};
            lvbl_sr <= {lvbl_sr[BL_DEPTH-2:0], raster.lvbl};
        end
    end

    assign vis = lhbl_sr[BL_DEPTH-1] & lvbl_sr[BL_DEPTH-1];

    // 5-bit channels widened by repeating the top bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
        end else begin
            red      <= vis ? {pal_q.red,   pal_q.red[4:2]}   : 8'd0;
            green    <= vis ? {pal_q.green, pal_q.green[4:2]} : 8'd0;
            blue     <= vis ? {pal_q.blue,  pal_q.blue[4:2]}  : 8'd0;
            lhbl_dly <= lhbl_sr[BL_DEPTH-1];
            lvbl_dly <= lvbl_sr[BL_DEPTH-1];
        end
    end

endmodule

`default_nettype wire

// ==== design/vid_top.sv ====
/*
 * Tile video subsystem top level
 * Raster timing, CPU decoder, two scrolling tile layers and the mixer
 */
`timescale 1ns/1ps
`default_nettype none

module vid_top #(
    parameter int MAP_COLS = 8,
    parameter int MAP_ROWS = 8
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic [8:0]         cpu_addr,
    input  vid_pkg::cpu_word_u      cpu_din,
    input  wire logic               cpu_we,
    input  wire logic               cpu_rd,
    output logic [15:0]             cpu_dout,
    output logic [10:0]             rom0_addr,
    input  wire logic [31:0]        rom0_data,
    output logic [10:0]             rom1_addr,
    input  wire logic [31:0]        rom1_data,
    output logic                    hs,
    output logic                    vs,
    output logic [8:0]              hdump,
    output logic [8:0]              vdump,
    output logic [7:0]              red,
    output logic [7:0]              green,
    output logic [7:0]              blue,
    output logic                    lhbl_dly,
    output logic                    lvbl_dly
);

    vid_pkg::raster_t    raster;
    vid_pkg::scroll_t    scroll0;
    vid_pkg::scroll_t    scroll1;
    vid_pkg::cpu_word_u  wdata;
    vid_pkg::layer_pxl_t pxl0;
    vid_pkg::layer_pxl_t pxl1;
    logic [5:0]          map_widx;
    logic [5:0]          pal_widx;
    logic                map0_we;
    logic                map1_we;
    logic                pal_we;
    logic                prio;
    logic [15:0]         map0_rdata;
    logic [15:0]         map1_rdata;
    logic [15:0]         pal_rdata;

    assign hdump = raster.hdump;
    assign vdump = raster.vdump;

    vid_timing u_timing (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .raster     ( raster        ),
        .hs         ( hs            ),
        .vs         ( vs            )
    );

    vid_regs u_regs (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .cpu_addr   ( cpu_addr      ),
        .cpu_din    ( cpu_din       ),
        .cpu_we     ( cpu_we        ),
        .cpu_rd     ( cpu_rd        ),
        .map0_rdata ( map0_rdata    ),
        .map1_rdata ( map1_rdata    ),
        .pal_rdata  ( pal_rdata     ),
        .map_widx   ( map_widx      ),
        .pal_widx   ( pal_widx      ),
        .map0_we    ( map0_we       ),
        .map1_we    ( map1_we       ),
        .pal_we     ( pal_we        ),
        .wdata      ( wdata         ),
        .scroll0    ( scroll0       ),
        .scroll1    ( scroll1       ),
        .prio       ( prio          ),
        .cpu_dout   ( cpu_dout      )
    );

    tile_layer #(
        .MAP_COLS   ( MAP_COLS      ),
        .MAP_ROWS   ( MAP_ROWS      )
    ) u_layer0 (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .raster     ( raster        ),
        .scroll     ( scroll0       ),
        .map_we     ( map0_we       ),
        .map_widx   ( map_widx      ),
        .wdata      ( wdata         ),
        .map_ridx   ( cpu_addr[5:0] ),
        .map_rdata  ( map0_rdata    ),
        .rom_addr   ( rom0_addr     ),
        .rom_data   ( rom0_data     ),
        .pxl        ( pxl0          )
    );

    tile_layer #(
        .MAP_COLS   ( MAP_COLS      ),
        .MAP_ROWS   ( MAP_ROWS      )
    ) u_layer1 (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .raster     ( raster        ),
        .scroll     ( scroll1       ),
        .map_we     ( map1_we       ),
        .map_widx   ( map_widx      ),
        .wdata      ( wdata         ),
        .map_ridx   ( cpu_addr[5:0] ),
        .map_rdata  ( map1_rdata    ),
        .rom_addr   ( rom1_addr     ),
        .rom_data   ( rom1_data     ),
        .pxl        ( pxl1          )
    );

    pal_mixer u_mixer (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .raster     ( raster        ),
        .prio       ( prio          ),
        .pxl0       ( pxl0          ),
        .pxl1       ( pxl1          ),
        .pal_we     ( pal_we        ),
        .pal_widx   ( pal_widx      ),
        .wdata      ( wdata         ),
        .pal_ridx   ( cpu_addr[5:0] ),
        .pal_rdata  ( pal_rdata     ),
        .red        ( red           ),
        .green      ( green         ),
        .blue       ( blue          ),
        .lhbl_dly   ( lhbl_dly      ),
        .lvbl_dly   ( lvbl_dly      )
    );

endmodule

`default_nettype wire

// ==== tb/vid_asserts.sv ====
/*
 * Bound checks for the video top level
 * Bus strobe exclusion, blanked RGB and pixel counter stepping
 */
`timescale 1ns/1ps
`default_nettype none

module vid_asserts (
    input wire logic       clk,
    input wire logic       arst_n,
    input wire logic       cpu_we,
    input wire logic       cpu_rd,
    input wire logic [8:0] hdump,
    input wire logic [7:0] red,
    input wire logic [7:0] green,
    input wire logic [7:0] blue,
    input wire logic       lhbl_dly
);

    int fail_count = 0;

    // Read and write never share a cycle
    strobe_excl: assert property (@(posedge clk) disable iff (!arst_n) !(cpu_we && cpu_rd))
        else begin
            $error("cpu_we and cpu_rd are high in the same cycle");
            fail_count++;
        end

    blank_black: assert property (@(posedge clk) disable iff (!arst_n)
                                  !lhbl_dly |-> ({red, green, blue} == 24'd0))
        else begin
            $error("rgb is not zero during horizontal blanking");
            fail_count++;
        end

    // Pixel counter wraps at the line length, from the first clock out of reset
    hdump_step: assert property (@(posedge clk) disable iff (!arst_n)
                                 $past(arst_n) |->
                                 hdump == (($past(hdump) == vid_pkg::H_TOTAL - 9'd1) ?
                                           9'd0 : $past(hdump) + 9'd1))
        else begin
            $error("hdump did not step by one modulo the line length");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== tb/tb_vid_top.sv ====
/*
 * Testbench for the tile video subsystem
 * Replays a trace of CPU writes, readbacks and expected pixels against
 * the top level, with behavioral models of both pattern ROMs
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vid_top;

    localparam int PIX_LAT   = vid_pkg::PIX_LAT;
    localparam int RD_LAT    = vid_pkg::RD_LAT;
    localparam int MAX_LINES = 64;

    logic               clk;
    logic               arst_n;
    logic [8:0]         cpu_addr;
    vid_pkg::cpu_word_u cpu_din;
    logic               cpu_we;
    logic               cpu_rd;
    logic [15:0]        cpu_dout;
    logic [10:0]        rom0_addr;
    logic [31:0]        rom0_data;
    logic [10:0]        rom1_addr;
    logic [31:0]        rom1_data;
    logic               hs;
    logic               vs;
    logic [8:0]         hdump;
    logic [8:0]         vdump;
    logic [7:0]         red;
    logic [7:0]         green;
    logic [7:0]         blue;
    logic               lhbl_dly;
    logic               lvbl_dly;

    // Four words per trace record
    logic [31:0] trace_mem [0:4*MAX_LINES-1];
    logic [17:0] coord_hist [0:PIX_LAT-1];
    logic [10:0] rom0_last;
    logic [10:0] rom1_last;
    logic        trace_ready = 1'b0;
    longint      timeout_ns;
    int          errors;
    int          checks;

    vid_top u_vid_top (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_din   ( cpu_din   ),
        .cpu_we    ( cpu_we    ),
        .cpu_rd    ( cpu_rd    ),
        .cpu_dout  ( cpu_dout  ),
        .rom0_addr ( rom0_addr ),
        .rom0_data ( rom0_data ),
        .rom1_addr ( rom1_addr ),
        .rom1_data ( rom1_data ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  )
    );

    bind vid_top vid_asserts u_asserts (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .cpu_we   ( cpu_we   ),
        .cpu_rd   ( cpu_rd   ),
        .hdump    ( hdump    ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl_dly ( lhbl_dly )
    );

    always #5 clk = ~clk;

    // Pattern nibble i of a row is (code + row + i) mod 16
    function automatic logic [31:0] rom_word(input logic [10:0] addr);
        logic [31:0] word;
        int          i;
        word = '0;
        for (i = 0; i < 8; i++) begin
            word[i*4 +: 4] = 4'(addr[10:3] + addr[2:0] + i);
        end
        return word;
    endfunction

    // Data for an address shows up one clock later
    always @(posedge clk) begin
        #1;
        rom0_data = rom_word(rom0_last);
        rom1_data = rom_word(rom1_last);
        rom0_last = rom0_addr;
        rom1_last = rom1_addr;
    end

    // Oldest entry is the coordinate that rgb currently belongs to
    always @(posedge clk) begin
        int k;
        coord_hist[0] <= {hdump, vdump};
        for (k = 1; k < PIX_LAT; k++) begin
            coord_hist[k] <= coord_hist[k-1];
        end
    end

    // Sync pulses, hs over hdump 52 to 55 and vs over vdump 34 to 35
    always @(negedge clk) begin
        logic exp_hs;
        logic exp_vs;
        exp_hs = (hdump >= 9'd52) && (hdump <= 9'd55);
        exp_vs = (vdump >= 9'd34) && (vdump <= 9'd35);
        if (arst_n === 1'b1) begin
            checks += 2;
            if (hs !== exp_hs) begin
                $display("ERROR [hsync at %0d,%0d] expected %b actual %b",
                         hdump, vdump, exp_hs, hs);
                errors++;
            end
            if (vs !== exp_vs) begin
                $display("ERROR [vsync at %0d,%0d] expected %b actual %b",
                         hdump, vdump, exp_vs, vs);
                errors++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_gap();
        int n;
        n = $urandom % 4;
        repeat (n) next_cycle();
    endtask

    task automatic bus_write(input logic [8:0] addr, input logic [15:0] data);
        cpu_addr = addr;
        cpu_din  = data;
        cpu_we   = 1'b1;
        next_cycle();
        cpu_we   = 1'b0;
    endtask

    // Old word must hold until the read latency has passed
    task automatic bus_read_check(input logic [8:0] addr, input logic [15:0] exp, input int line);
        int          n;
        logic [15:0] prev;
        prev     = cpu_dout;
        cpu_addr = addr;
        cpu_rd   = 1'b1;
        for (n = 0; n < RD_LAT; n++) begin
            next_cycle();
            cpu_rd = 1'b0;
            if (n < RD_LAT - 1) begin
                checks++;
                if (cpu_dout !== prev) begin
                    $display("ERROR [read latency line %0d addr %03h] expected %04h actual %04h",
                             line, addr, prev, cpu_dout);
                    errors++;
                end
            end
        end
        checks++;
        if (cpu_dout !== exp) begin
            $display("ERROR [readback line %0d addr %03h] expected %04h actual %04h",
                     line, addr, exp, cpu_dout);
            errors++;
        end
    endtask

    // Wait for the coordinate to enter the pipeline, then for it to come out
    task automatic pixel_check(input logic [8:0] h, input logic [8:0] v,
                               input logic [23:0] exp, input int line);
        logic seen;
        logic done;
        logic exp_hbl;
        logic exp_vbl;
        seen    = 1'b0;
        done    = 1'b0;
        exp_hbl = (h < vid_pkg::H_VIS);
        exp_vbl = (v < vid_pkg::V_VIS);
        while (!done) begin
            if (seen && coord_hist[PIX_LAT-1] == {h, v}) begin
                checks += 2;
                if ({red, green, blue} !== exp) begin
                    $display("ERROR [pixel line %0d at %0d,%0d] expected %06h actual %06h",
                             line, h, v, exp, {red, green, blue});
                    errors++;
                end
                if ({lhbl_dly, lvbl_dly} !== {exp_hbl, exp_vbl}) begin
                    $display("ERROR [blanking line %0d at %0d,%0d] expected %b%b actual %b%b",
                             line, h, v, exp_hbl, exp_vbl, lhbl_dly, lvbl_dly);
                    errors++;
                end
                done = 1'b1;
            end else begin
                if (hdump == h && vdump == v) begin
                    seen = 1'b1;
                end
                next_cycle();
            end
        end
    endtask

    initial begin
        int          line_cnt;
        int          i;
        logic [31:0] kind;
        logic [31:0] fa;
        logic [31:0] fb;
        logic [31:0] fc;
        clk       = 1'b0;
        arst_n    = 1'b0;
        cpu_addr  = '0;
        cpu_din   = '0;
        cpu_we    = 1'b0;
        cpu_rd    = 1'b0;
        rom0_data = '0;
        rom1_data = '0;
        errors    = 0;
        checks    = 0;
        void'($urandom(32'h37c9));
        for (i = 0; i < 4 * MAX_LINES; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("tb/vid_trace.txt", trace_mem);
        line_cnt = 0;
        while (line_cnt < MAX_LINES && trace_mem[line_cnt*4] != 0) begin
            line_cnt++;
        end
        if (line_cnt == 0) begin
            $display("Trace file tb/vid_trace.txt holds no records");
            errors++;
        end
        timeout_ns  = longint'(line_cnt + 3) * vid_pkg::H_TOTAL * vid_pkg::V_TOTAL * 10;
        trace_ready = 1'b1;

        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (i = 0; i < line_cnt; i++) begin
            kind = trace_mem[i*4];
            fa   = trace_mem[i*4+1];
            fb   = trace_mem[i*4+2];
            fc   = trace_mem[i*4+3];
            case (kind)
                32'd1:   bus_write(fa[8:0], fb[15:0]);
                32'd2:   bus_read_check(fa[8:0], fb[15:0], i + 1);
                32'd3:   pixel_check(fa[8:0], fb[8:0], fc[23:0], i + 1);
                default: begin
                    $display("Trace record %0d has an unknown kind %0h", i + 1, kind);
                    errors++;
                end
            endcase
            idle_gap();
        end

        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_vid_top.u_asserts.fail_count);
        if (errors == 0 && u_vid_top.u_asserts.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (trace_ready);
        #(timeout_ns);
        $display("Timeout: the trace did not complete within %0d ns", timeout_ns);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/vid_trace.txt ====
// kind 1 write: addr data 0 | kind 2 read: addr expected_data 0
// kind 3 pixel: hdump vdump expected_rgb (red, green, blue bytes)
1 000 0801 0
1 001 8801 0
1 040 000B 0
1 096 7C00 0
1 097 03E0 0
1 099 07EC 0
1 0A1 4103 0
2 001 8801 0
2 0A1 4103 0
2 100 FFFF 0
3 002 003 FF0000
3 003 003 00FF00
3 00A 003 08FF63
3 032 003 000000
3 002 023 000000
1 0C4 0001 0
2 0C4 0001 0
3 002 003 FF0000
3 003 003 844218
1 0C4 0000 0
1 0C0 003E 0
1 0C1 003E 0
2 0C0 003E 0
3 005 004 FF0000
3 00D 004 00FF00

// ==== src.f ====
design/vid_pkg.sv
design/vid_timing.sv
design/vid_regs.sv
design/tile_layer.sv
design/pal_mixer.sv
design/vid_top.sv
tb/vid_asserts.sv
tb/tb_vid_top.sv

// ==== Bender.yml ====
package:
  name: vid_tile

sources:
  - design/vid_pkg.sv
  - design/vid_timing.sv
  - design/vid_regs.sv
  - design/tile_layer.sv
  - design/pal_mixer.sv
  - design/vid_top.sv
  - target: simulation
    files:
      - tb/vid_asserts.sv
      - tb/tb_vid_top.sv
